//--- rtl/spio_link_defines.svh
// ----------------------------------------------------------------------
// sizes and per-link-type tables for the 2-of-7 link sender
// included by the package and by any RTL module that needs the numbers
// ----------------------------------------------------------------------
`ifndef SPIO_LINK_DEFINES_SVH
`define SPIO_LINK_DEFINES_SVH

`define PKT_BITS        72   // long packet word, short ones use the low 40
`define SYM_BITS        7    // wires on the link
`define NIB_BITS        4    // one data flit carries a nibble
`define SHORT_FLITS     10   // data nibbles, short packet
`define LONG_FLITS      18   // data nibbles, long packet

`define FLT_CNT_BITS    5    // serializer flit counter
`define LNK_CNT_BITS    6    // data / ack burst counters
`define DLY_CNT_BITS    8    // inter-flit spacing counter

`define BSF_SHORT       11   // sync flits per burst, short packets

// back-pressure tables, entry 0 in the low bits
`define NUM_LINK_TYPES  6
`define BPP_BITS        4
`define BSF_BITS        5
`define BAF_BITS        3
`define BPP_TABLE       {4'd5, 4'd6, 4'd6, 4'd9, 4'd6, 4'd7}
`define BSF_LONG_TABLE  {5'd15, 5'd17, 5'd17, 5'd17, 5'd17, 5'd17}
`define BAF_LONG_TABLE  {3'd4, 3'd2, 3'd2, 3'd2, 3'd2, 3'd2}

`endif

//--- rtl/spio_link_pkg.sv
// ----------------------------------------------------------------------
// shared types for the link sender: packet word, link symbol and the
// NRZ 2-of-7 code table with its encoder
// ----------------------------------------------------------------------
`include "spio_link_defines.svh"

package spio_link_pkg;

  // packet word, seen either as nibbles or as SpiNNaker fields
  typedef union packed {
    logic [`LONG_FLITS-1:0][`NIB_BITS-1:0] nib;  // nib[0] goes out first
    struct packed {
      logic [31:0] payload;  // only in long packets
      logic [31:0] key;      // routing key
      logic [7:0]  header;   // bit 1 long flag, bit 0 parity
    } fld;
  } pkt_word_u;

  typedef logic [`SYM_BITS-1:0] sym_t;  // one level per link wire

  // --------------------------------------------------------------------
  // 2-of-7 transition codes, entries 0..15 data, 16 end-of-packet
  // --------------------------------------------------------------------
  localparam sym_t code_2of7 [0:16] = '{
    7'b0010001, 7'b0010010, 7'b0010100, 7'b0011000,  // 0..3
    7'b0100001, 7'b0100010, 7'b0100100, 7'b0101000,  // 4..7
    7'b1000001, 7'b1000010, 7'b1000100, 7'b1001000,  // 8..11
    7'b0000011, 7'b0000110, 7'b0001100, 7'b0001001,  // 12..15
    7'b1100000                                       // eop
  };

  // NRZ: the new level is the old one with exactly two wires flipped
  function automatic sym_t nrz_2of7(input logic [`NIB_BITS:0] code,
                                    input sym_t prev);
    sym_t delta;
    if (code[`NIB_BITS]) begin
      delta = code_2of7[16];  // eop flag wins over the nibble
    end else begin
      delta = code_2of7[code[`NIB_BITS-1:0]];
    end
    return prev ^ delta;
  endfunction

endpackage

//--- rtl/pkt_serializer.sv
// ----------------------------------------------------------------------
// packet serializer: takes one packet at a time, parks it while the
// output is busy and hands out NRZ 2-of-7 flits ending with eop
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "spio_link_defines.svh"

module pkt_serializer (
  input  logic                     CLK_IN,
  input  logic                     RESET_IN,
  // packet side
  input  spio_link_pkg::pkt_word_u pkt_data,
  input  logic                     pkt_vld,
  output logic                     pkt_rdy,
  // flit side
  output spio_link_pkg::sym_t      flt_data,
  output logic                     flt_psz,
  output logic                     flt_vld,
  input  logic                     flt_rdy
);
  import spio_link_pkg::*;

  // ----------------------------------------------------------------------
  // states
  // ----------------------------------------------------------------------
  localparam logic [1:0] st_idle = 2'd0;  // waiting for a packet
  localparam logic [1:0] st_park = 2'd1;  // whole packet held, nothing sent
  localparam logic [1:0] st_tran = 2'd2;  // nibbles going out

  logic [1:0]               state;
  logic                     pkt_acpt;  // packet taken this cycle
  logic                     flt_busy;  // flit offered but not taken
  logic                     eop;       // next flit is end-of-packet
  pkt_word_u                pkt_buf;   // remaining nibbles, nib[0] next
  logic [`FLT_CNT_BITS-1:0] flt_cnt;   // data flits handed out so far

  assign pkt_acpt = pkt_vld && pkt_rdy;
  assign flt_busy = flt_vld && !flt_rdy;

  // flt_psz doubles as the size of the packet being sent
  assign eop = (!flt_psz && (flt_cnt == `FLT_CNT_BITS'(`SHORT_FLITS)))
            || (flt_cnt == `FLT_CNT_BITS'(`LONG_FLITS));

  // ----------------------------------------------------------------------
  // state machine
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (pkt_acpt) begin
            state <= flt_busy ? st_park : st_tran;  // park if output stuck
          end
        end
        st_park: begin
          if (!flt_busy) begin
            state <= st_tran;  // first nibble leaves now
          end
        end
        default: begin
          if (eop && !flt_busy) begin
            state <= st_idle;  // eop flit issued
          end
        end
      endcase
    end
  end

  // ready for the next packet only once eop is on its way
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_rdy <= 1'b0;  // rises one cycle after reset
    end else begin
      case (state)
        st_idle: pkt_rdy <= !pkt_acpt;
        st_park: pkt_rdy <= 1'b0;
        default: pkt_rdy <= eop && !flt_busy;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // nibble buffer
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK_IN) begin
    if (state == st_idle) begin
      if (pkt_acpt && flt_busy) begin
        pkt_buf <= pkt_data;  // park all of it
      end else if (pkt_acpt) begin
        // nibble 0 already sent
        pkt_buf <= {{`NIB_BITS{1'b0}}, pkt_data[`PKT_BITS-1:`NIB_BITS]};
      end
    end else if (!flt_busy) begin
      pkt_buf <= {{`NIB_BITS{1'b0}}, pkt_buf[`PKT_BITS-1:`NIB_BITS]};  // next one
    end
  end

  // ----------------------------------------------------------------------
  // flit outputs
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_data <= '0;  // link wires idle low
    end else if (state == st_idle) begin
      if (pkt_acpt && !flt_busy) begin
        flt_data <= nrz_2of7({1'b0, pkt_data.nib[0]}, flt_data);  // straight through
      end
    end else if (!flt_busy) begin
      flt_data <= nrz_2of7({eop, pkt_buf.nib[0]}, flt_data);  // data or eop
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_psz <= 1'b0;
    end else if ((state == st_idle) && pkt_acpt) begin
      flt_psz <= pkt_data.fld.header[1];  // long flag
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_vld <= 1'b0;
    end else if (state == st_idle) begin
      if (!flt_busy) begin
        flt_vld <= pkt_acpt;  // drops after eop unless a packet follows
      end
    end else begin
      flt_vld <= 1'b1;  // always something left while parked/sending
    end
  end

  // count data flits, eop falls due after 10 or 18
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_cnt <= `FLT_CNT_BITS'(1);
    end else if (state != st_tran) begin
      flt_cnt <= `FLT_CNT_BITS'(1);  // first nibble counted on entry
    end else if (!flt_busy) begin
      flt_cnt <= flt_cnt + 1'b1;
    end
  end

endmodule

//--- rtl/flit_output_if.sv
// ----------------------------------------------------------------------
// STAC flit scheduler: sends predictive bursts while acks keep up and
// falls back to one-flit-per-ack around the back-pressure point
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "spio_link_defines.svh"

module flit_output_if #(
  parameter int sl_type         = 3,
  parameter int inter_flt_delay = 1
) (
  input  logic                CLK_IN,
  input  logic                RESET_IN,
  // serializer side
  input  spio_link_pkg::sym_t flt_data,
  input  logic                flt_psz,
  input  logic                flt_vld,
  output logic                flt_rdy,
  // link side
  output spio_link_pkg::sym_t sl_data,
  input  logic                sl_ack
);

  // ----------------------------------------------------------------------
  // per-link-type burst sizes
  // ----------------------------------------------------------------------
  localparam logic [`BPP_BITS*`NUM_LINK_TYPES-1:0] bpp_tab = `BPP_TABLE;
  localparam logic [`BSF_BITS*`NUM_LINK_TYPES-1:0] bsf_tab = `BSF_LONG_TABLE;
  localparam logic [`BAF_BITS*`NUM_LINK_TYPES-1:0] baf_tab = `BAF_LONG_TABLE;

  localparam logic [`LNK_CNT_BITS-1:0] bpp =
    `LNK_CNT_BITS'(bpp_tab[`BPP_BITS*sl_type +: `BPP_BITS]);
  localparam logic [`LNK_CNT_BITS-1:0] bsf_long =
    `LNK_CNT_BITS'(bsf_tab[`BSF_BITS*sl_type +: `BSF_BITS]);
  localparam logic [`LNK_CNT_BITS-1:0] baf_long =
    `LNK_CNT_BITS'(baf_tab[`BAF_BITS*sl_type +: `BAF_BITS]);
  localparam logic [`LNK_CNT_BITS-1:0] bsf_short = `LNK_CNT_BITS'(`BSF_SHORT);
  localparam logic [`DLY_CNT_BITS-1:0] flt_gap   = `DLY_CNT_BITS'(inter_flt_delay);

  localparam logic st_sync = 1'b0;  // predictive burst
  localparam logic st_asyn = 1'b1;  // wait for each ack

  logic                     ack_s1, ack_s2;  // 2-ff synchronizer
  logic                     old_ack;   // ack level at last send
  logic                     oap;       // ack level last cycle
  logic                     acked;     // toggle since last send
  logic                     akp;       // toggle this cycle
  logic                     snd_asyn;  // first async flit may go unacked
  logic                     pps;       // size of the previous packet
  logic                     send_flit;
  logic [`LNK_CNT_BITS-1:0] dat_cnt;   // data flits left in burst
  logic [`LNK_CNT_BITS-1:0] ack_cnt;   // acks still expected
  logic                     dat_dne;
  logic                     ack_dne;
  logic [`DLY_CNT_BITS-1:0] dly_cnt;   // spacing between sync flits
  logic                     state;

  // ----------------------------------------------------------------------
  // acknowledge synchronizer and toggle detection
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      ack_s1 <= 1'b0;
      ack_s2 <= 1'b0;
      oap    <= 1'b0;
    end else begin
      ack_s1 <= sl_ack;
      ack_s2 <= ack_s1;
      oap    <= ack_s2;
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      old_ack <= 1'b0;
    end else if (send_flit) begin
      old_ack <= ack_s2;  // snapshot per symbol sent
    end
  end

  assign acked   = (old_ack != ack_s2);
  assign akp     = (oap != ack_s2);
  assign dat_dne = (dat_cnt == '0);
  assign ack_dne = (ack_cnt == '0) || ((ack_cnt == `LNK_CNT_BITS'(1)) && akp);

  // sync: on handshake; async: on ack of previous flit, never past burst
  assign send_flit = (state == st_sync) ? (flt_vld && flt_rdy)
                                        : (flt_vld && (acked || snd_asyn) && !dat_dne);

  // ----------------------------------------------------------------------
  // link output and serializer handshake
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      sl_data <= '0;
    end else if (send_flit) begin
      sl_data <= flt_data;  // two wires toggle
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_rdy <= 1'b1;
    end else if (state == st_sync) begin
      if (send_flit) begin
        flt_rdy <= 1'b0;  // just sent, wait out the gap
      end else if (ack_dne) begin
        flt_rdy <= !pps;  // next burst, unless going async
      end else if (!dat_dne && (dly_cnt == `DLY_CNT_BITS'(1))) begin
        flt_rdy <= 1'b1;  // gap over
      end
    end else begin
      flt_rdy <= send_flit || ack_dne;  // rdy trails the async send
    end
  end

  // ----------------------------------------------------------------------
  // burst bookkeeping
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pps <= 1'b0;  // assume short to start
    end else if (ack_dne && ((state == st_asyn) || !pps)) begin
      pps <= flt_psz;
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      snd_asyn <= 1'b0;
    end else begin
      snd_asyn <= (state == st_sync) && ack_dne && pps;  // entering async
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      dat_cnt <= bpp;
    end else if (send_flit) begin
      dat_cnt <= dat_cnt - 1'b1;
    end else if (ack_dne) begin
      if ((state == st_sync) && pps) begin
        dat_cnt <= baf_long;  // async tail of long burst
      end else begin
        dat_cnt <= flt_psz ? bsf_long : bsf_short;
      end
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      ack_cnt <= bpp + 1'b1;  // the link acks once on reset
    end else if (ack_dne) begin
      if ((state == st_sync) && pps) begin
        ack_cnt <= baf_long;
      end else begin
        ack_cnt <= flt_psz ? bsf_long : bsf_short;
      end
    end else if (akp) begin
      ack_cnt <= ack_cnt - 1'b1;
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      dly_cnt <= '0;
    end else if (send_flit) begin
      dly_cnt <= flt_gap;  // restart spacing
    end else if (dly_cnt != '0) begin
      dly_cnt <= dly_cnt - 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // sync / async mode
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= st_sync;
    end else if (state == st_sync) begin
      if (ack_dne && pps) begin
        state <= st_asyn;  // long burst reached its back-pressure point
      end
    end else if (ack_dne) begin
      state <= st_sync;
    end
  end

endmodule

//--- rtl/spio_link_sender.sv
// ----------------------------------------------------------------------
// transmit side of a 2-of-7 chip link: packets in on valid/ready,
// NRZ symbols out on seven wires, paced by STAC flow control
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module spio_link_sender #(
  parameter int sl_type         = 3,  // link type, selects back-pressure point
  parameter int inter_flt_delay = 1   // cycles between sync flits
) (
  input  logic                     CLK_IN,
  input  logic                     RESET_IN,
  // packet side
  input  spio_link_pkg::pkt_word_u pkt_data,
  input  logic                     pkt_vld,
  output logic                     pkt_rdy,
  // link side
  output spio_link_pkg::sym_t      sl_data,
  input  logic                     sl_ack    // async, toggles per symbol
);
  import spio_link_pkg::*;

  // serializer -> output interface
  sym_t flt_data;  // next level for the wires
  logic flt_psz;   // 1 = long packet in flight
  logic flt_vld;
  logic flt_rdy;

  pkt_serializer ser0 (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .flt_data (flt_data),
    .flt_psz  (flt_psz),
    .flt_vld  (flt_vld),
    .flt_rdy  (flt_rdy)
  );

  flit_output_if #(
    .sl_type         (sl_type),
    .inter_flt_delay (inter_flt_delay)
  ) fout0 (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .flt_data (flt_data),
    .flt_psz  (flt_psz),
    .flt_vld  (flt_vld),
    .flt_rdy  (flt_rdy),
    .sl_data  (sl_data),
    .sl_ack   (sl_ack)     // synchronized inside fout0
  );

endmodule

//--- verification/spio_link_sender_chk.sv
// ----------------------------------------------------------------------
// concurrent checks on the link sender, bound into the top level
// fail_cnt is read by the testbench at the end of the run
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module spio_link_sender_chk (
  input logic                CLK_IN,
  input logic                RESET_IN,
  input logic                pkt_vld,
  input logic                pkt_rdy,
  input spio_link_pkg::sym_t sl_data,
  input logic                sl_ack
);
  int                  fail_cnt = 0;  // assertion failures so far
  int                  sym_cnt;       // symbols put on the wires
  int                  ack_cnt;       // ack toggles seen
  spio_link_pkg::sym_t last_sym;
  logic                last_ack;

  // symbol / ack scoreboard, one count per level change
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      sym_cnt  <= 0;
      ack_cnt  <= 0;
      last_sym <= '0;
      last_ack <= 1'b0;
    end else begin
      if (sl_data != last_sym) begin
        sym_cnt <= sym_cnt + 1;
      end
      if (sl_ack != last_ack) begin
        ack_cnt <= ack_cnt + 1;
      end
      last_sym <= sl_data;
      last_ack <= sl_ack;
    end
  end

  // ----------------------------------------------------------------------
  // properties
  // ----------------------------------------------------------------------
  reset_idle: assert property (@(posedge CLK_IN)
    $fell(RESET_IN) |-> (sl_data == '0) ##[0:2] pkt_rdy)
    else begin
      $error("wires not idle or pkt_rdy late after reset");
      fail_cnt++;
    end

  two_wires: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    (sl_data != $past(sl_data)) |-> ($countones(sl_data ^ $past(sl_data)) == 2))
    else begin
      $error("symbol change is not a 2-of-7 transition");
      fail_cnt++;
    end

  rdy_drop: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    (pkt_vld && pkt_rdy) |=> !pkt_rdy)
    else begin
      $error("pkt_rdy still high after an accept");
      fail_cnt++;
    end

  // largest burst plus the reset ack
  ack_window: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    (sym_cnt - ack_cnt) <= 19)
    else begin
      $error("too many symbols sent without acknowledge");
      fail_cnt++;
    end

endmodule

//--- verification/tb_spio_link_sender.sv
// ----------------------------------------------------------------------
// testbench for the 2-of-7 link sender: random packets in, a receiver
// model that acks and decodes the wires, bound assertions alongside
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "spio_link_defines.svh"

module tb_spio_link_sender;
  import spio_link_pkg::*;

  logic        CLK_IN;
  logic        RESET_IN;
  pkt_word_u   pkt_data;
  logic        pkt_vld;
  logic        pkt_rdy;
  sym_t        sl_data;
  logic        sl_ack;

  logic [31:0] pkt_lfsr = 32'h0b33_a834;  // packet fields and sizes
  logic [31:0] ack_lfsr = 32'h0b33_a834;  // receiver delays
  pkt_word_u   sent_q[$];                  // accepted, oldest first
  pkt_word_u   rx_word;                    // packet being rebuilt
  int          rx_nibs;
  int          rx_cnt = 0;
  int          tx_cnt = 0;
  int          errors = 0;
  bit          timed_out = 1'b0;
  bit          ack_stall = 1'b0;
  int          ack_pend;                   // symbols not acked yet
  int          ack_wait;                   // cycles before next ack
  sym_t        last_sym;

  spio_link_sender #(
    .sl_type         (3),
    .inter_flt_delay (1)
  ) dut0 (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .sl_data  (sl_data),
    .sl_ack   (sl_ack)
  );

  bind spio_link_sender spio_link_sender_chk chk0 (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .sl_data  (sl_data),
    .sl_ack   (sl_ack)
  );

  initial begin
    CLK_IN = 1'b0;
    forever #2 CLK_IN = ~CLK_IN;  // 4 ns period
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_bits(inout logic [31:0] st, input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], st[0]};
      st  = st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
    end
    return val;
  endfunction

  // reverse code table lookup, -1 for a non-code
  function automatic int sym_code(input sym_t delta);
    int idx;
    idx = -1;
    for (int i = 0; i <= 16; i++) begin
      if (code_2of7[i] == delta) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    errors++;
  endtask

  function automatic pkt_word_u make_packet();
    pkt_word_u p;
    p.fld.payload   = lfsr_bits(pkt_lfsr, 32);
    p.fld.key       = lfsr_bits(pkt_lfsr, 32);
    p.fld.header    = 8'(lfsr_bits(pkt_lfsr, 8));
    p.fld.header[1] = (lfsr_bits(pkt_lfsr, 1) == 32'd1);  // long flag
    if (!p.fld.header[1]) begin
      p.fld.payload = '0;  // short packets stop at the key
    end
    p.fld.header[0] = ^{p.fld.payload, p.fld.key, p.fld.header[7:1]};  // parity
    return p;
  endfunction

  task automatic offer_packet();
    pkt_data = make_packet();
    pkt_vld  = 1'b1;
  endtask

  // pkt_rdy read after the edge holds through the next one
  task automatic wait_accept();
    int tmo;
    tmo = 0;
    while (!pkt_rdy && tmo < 2000) begin
      @(posedge CLK_IN);
      #1;
      tmo++;
    end
    if (!pkt_rdy) begin
      $display("timeout waiting for pkt_rdy");
      timed_out = 1'b1;
    end else begin
      @(posedge CLK_IN);  // accepted here
      #1;
      sent_q.push_back(pkt_data);
      tx_cnt++;
      pkt_vld = 1'b0;
    end
  endtask

  // decode one transition, compare at eop
  task automatic absorb_symbol(input sym_t delta);
    int        code;
    int        exp_nibs;
    pkt_word_u exp_word;
    code = sym_code(delta);
    assert (code >= 0) else report_fail($sformatf("bad transition %b", delta));
    if (code >= 0 && code < 16) begin
      if (rx_nibs < `LONG_FLITS) begin
        rx_word.nib[rx_nibs] = code[3:0];
      end
      rx_nibs++;
    end else if (code == 16) begin
      assert (sent_q.size() > 0) else report_fail("eop with no packet sent");
      if (sent_q.size() > 0) begin
        exp_word = sent_q.pop_front();
        exp_nibs = exp_word.fld.header[1] ? `LONG_FLITS : `SHORT_FLITS;
        assert (rx_nibs == exp_nibs)
          else report_fail($sformatf("%0d nibbles, expected %0d", rx_nibs, exp_nibs));
        assert (rx_word == exp_word)
          else report_fail($sformatf("packet %0d is %h, expected %h", rx_cnt, rx_word, exp_word));
      end
      rx_cnt++;
      rx_nibs = 0;
      rx_word = '0;
    end
  endtask

  // ----------------------------------------------------------------------
  // receiver model: one look per cycle, acks trail the symbols
  // ----------------------------------------------------------------------
  always begin
    @(posedge CLK_IN);
    #1;
    if (RESET_IN) begin
      last_sym = '0;
      ack_pend = 1;  // link acks once out of reset
      ack_wait = 0;
      rx_nibs  = 0;
      rx_word  = '0;
    end else begin
      if (sl_data != last_sym) begin
        absorb_symbol(sl_data ^ last_sym);
        last_sym = sl_data;
        ack_pend++;
      end
      if (ack_wait > 0) begin
        ack_wait--;
      end else if (ack_pend > 0 && !ack_stall) begin
        sl_ack   = ~sl_ack;
        ack_pend--;
        ack_wait = lfsr_bits(ack_lfsr, 3);  // 0..7 cycles
        if (lfsr_bits(ack_lfsr, 4) == 0) begin
          ack_wait = 30;  // now and then a long stall
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial begin
    int   tmo;
    bit   accepted;
    sym_t frozen;
    RESET_IN = 1'b1;
    pkt_vld  = 1'b0;
    pkt_data = '0;
    sl_ack   = 1'b0;
    repeat (3) @(posedge CLK_IN);
    #1;
    RESET_IN = 1'b0;
    for (int i = 0; i < 30 && !timed_out; i++) begin
      offer_packet();
      wait_accept();
    end
    // acks held back while packets keep coming
    if (!timed_out) begin
      ack_stall = 1'b1;
      offer_packet();
      for (int c = 0; c < 100; c++) begin
        accepted = pkt_vld && pkt_rdy;
        @(posedge CLK_IN);
        #1;
        if (accepted) begin
          sent_q.push_back(pkt_data);
          tx_cnt++;
          pkt_data = make_packet();
        end
        if (c == 70) begin
          frozen = sl_data;  // link should be stuck by now
        end
        if (c > 70) begin
          assert (sl_data == frozen) else report_fail("sl_data moved with acks stalled");
        end
      end
      ack_stall = 1'b0;
      wait_accept();
    end
    for (int i = 0; i < 20 && !timed_out; i++) begin
      offer_packet();
      wait_accept();
    end
    tmo = 0;
    while (!timed_out && rx_cnt < tx_cnt && tmo < 5000) begin
      @(posedge CLK_IN);
      #1;
      tmo++;
    end
    if (!timed_out && rx_cnt < tx_cnt) begin
      $display("timeout waiting for packets on the link");
      timed_out = 1'b1;
    end
    $display("errors: %0d testbench, %0d assertion; %0d of %0d packets received",
             errors, dut0.chk0.fail_cnt, rx_cnt, tx_cnt);
    if (errors == 0 && dut0.chk0.fail_cnt == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+rtl
rtl/spio_link_pkg.sv
rtl/pkt_serializer.sv
rtl/flit_output_if.sv
rtl/spio_link_sender.sv
verification/spio_link_sender_chk.sv
verification/tb_spio_link_sender.sv
